/* rtl/ramBridgePkg.sv */
package ramBridgePkg;

	// --------------------------------------------------
	// bus widths
	// --------------------------------------------------

	// width of one memory data word
	localparam int lpRamDqWidth = 8;

	// address width, kept small so the array fits in simulation
	localparam int lpRamAdrsWidth = 10;

	// width of the client id returned with read data
	localparam int lpUfiIdNumber = 3;

	// --------------------------------------------------
	// fifo depths
	// --------------------------------------------------

	// every dual-clock lane, power of two
	localparam int lpDualClkFifoDepth = 16;

	// id lane holds ids of reads still queued or in the return lane
	localparam int lpIdFifoDepth = lpDualClkFifoDepth << 1;

	// --------------------------------------------------
	// command encoding
	// --------------------------------------------------
	localparam logic lpCmdWrite = 1'b0;
	localparam logic lpCmdRead = 1'b1;

endpackage

/* rtl/fifoDualControllerGray.sv */
module fifoDualControllerGray #(
	parameter int pDepth = 16,
	parameter int pWidth = 8
)(
	input  logic              srcClk,
	input  logic              dstClk,
	input  logic              rstN,
	input  logic [pWidth-1:0] wd,
	input  logic              we,
	input  logic              re,
	output logic              full,
	output logic [pWidth-1:0] rd,
	output logic              rvd,
	output logic              emp
);

	// address bits, pointers carry one extra wrap bit
	localparam int lpAdrsWidth = $clog2(pDepth);

	logic [1:0]             srcRstSync;
	logic [1:0]             dstRstSync;
	logic                   srcRstN;
	logic                   dstRstN;
	logic [pWidth-1:0]      mem [pDepth];
	logic                   wPush;
	logic                   rPop;
	logic [lpAdrsWidth:0]   wBin;
	logic [lpAdrsWidth:0]   wBinNext;
	logic [lpAdrsWidth:0]   wGray;
	logic [lpAdrsWidth:0]   rBin;
	logic [lpAdrsWidth:0]   rBinNext;
	logic [lpAdrsWidth:0]   rGray;
	logic [lpAdrsWidth:0]   rGraySrc1;
	logic [lpAdrsWidth:0]   rGraySrc2;
	logic [lpAdrsWidth:0]   wGrayDst1;
	logic [lpAdrsWidth:0]   wGrayDst2;

	// --------------------------------------------------
	// reset synchronizers, one per domain
	// --------------------------------------------------

	// assert at once, release two edges later
	always_ff @(posedge srcClk or negedge rstN)
	begin
		if (!rstN)
			srcRstSync <= 2'b00;
		else
			srcRstSync <= {srcRstSync[0], 1'b1};
	end

	always_ff @(posedge dstClk or negedge rstN)
	begin
		if (!rstN)
			dstRstSync <= 2'b00;
		else
			dstRstSync <= {dstRstSync[0], 1'b1};
	end

	assign srcRstN = srcRstSync[1];
	assign dstRstN = dstRstSync[1];

	// --------------------------------------------------
	// write side, srcClk
	// --------------------------------------------------

	// a push into a full buffer is dropped
	assign wPush = we & ~full;
	assign wBinNext = wBin + {{lpAdrsWidth{1'b0}}, wPush};

	always_ff @(posedge srcClk or negedge srcRstN)
	begin
		if (!srcRstN)
		begin
			wBin <= '0;
			wGray <= '0;
		end
		else
		begin
			wBin <= wBinNext;
			// binary to gray, one bit flips per step
			wGray <= wBinNext ^ (wBinNext >> 1);
		end
	end

	// read pointer into the write domain
	always_ff @(posedge srcClk or negedge srcRstN)
	begin
		if (!srcRstN)
		begin
			rGraySrc1 <= '0;
			rGraySrc2 <= '0;
		end
		else
		begin
			rGraySrc1 <= rGray;
			rGraySrc2 <= rGraySrc1;
		end
	end

	// full when the writer is one lap ahead, top two gray bits differ
	assign full = (wGray == {~rGraySrc2[lpAdrsWidth:lpAdrsWidth-1],
		rGraySrc2[lpAdrsWidth-2:0]});

	// payload storage
	always_ff @(posedge srcClk)
	begin
		if (wPush)
			mem[wBin[lpAdrsWidth-1:0]] <= wd;
	end

	// --------------------------------------------------
	// read side, dstClk
	// --------------------------------------------------
	assign rPop = re & ~emp;
	assign rBinNext = rBin + {{lpAdrsWidth{1'b0}}, rPop};

	always_ff @(posedge dstClk or negedge dstRstN)
	begin
		if (!dstRstN)
		begin
			rBin <= '0;
			rGray <= '0;
			rvd <= 1'b0;
		end
		else
		begin
			rBin <= rBinNext;
			rGray <= rBinNext ^ (rBinNext >> 1);
			// data valid one edge after the strobe
			rvd <= rPop;
		end
	end

	// write pointer into the read domain
	always_ff @(posedge dstClk or negedge dstRstN)
	begin
		if (!dstRstN)
		begin
			wGrayDst1 <= '0;
			wGrayDst2 <= '0;
		end
		else
		begin
			wGrayDst1 <= wGray;
			wGrayDst2 <= wGrayDst1;
		end
	end

	// empty when both pointers match, lags a write by the sync stages
	assign emp = (rGray == wGrayDst2);

	always_ff @(posedge dstClk)
	begin
		if (rPop)
			rd <= mem[rBin[lpAdrsWidth-1:0]];
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// writer must watch full, a dropped word desyncs the lanes
	assert property (@(posedge srcClk) disable iff (!srcRstN) we |-> !full)
		else $error("fifoDualControllerGray: push while full");

	// reader must watch emp
	assert property (@(posedge dstClk) disable iff (!dstRstN) re |-> !emp)
		else $error("fifoDualControllerGray: pop while empty");

endmodule

/* rtl/fifoController.sv */
module fifoController #(
	parameter int pDepth = 32,
	parameter int pWidth = 3
)(
	input  logic              clk,
	input  logic              rstN,
	input  logic [pWidth-1:0] wd,
	input  logic              we,
	input  logic              re,
	output logic              full,
	output logic [pWidth-1:0] rd,
	output logic              rvd,
	output logic              emp
);

	// depth is a power of two, pointers wrap on their own
	localparam int lpAdrsWidth = $clog2(pDepth);
	localparam int lpCntWidth = $clog2(pDepth + 1);

	logic [1:0]             rstSync;
	logic                   syncRstN;
	logic [pWidth-1:0]      mem [pDepth];
	logic [lpAdrsWidth-1:0] wPtr;
	logic [lpAdrsWidth-1:0] rPtr;
	logic [lpCntWidth-1:0]  count;
	logic                   push;
	logic                   pop;

	// reset release on clk
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			rstSync <= 2'b00;
		else
			rstSync <= {rstSync[0], 1'b1};
	end

	assign syncRstN = rstSync[1];

	// --------------------------------------------------
	// occupancy and pointers
	// --------------------------------------------------

	// flags follow the counter in the same clock
	assign full = (count == lpCntWidth'(pDepth));
	assign emp = (count == '0);
	assign push = we & ~full;
	assign pop = re & ~emp;

	always_ff @(posedge clk or negedge syncRstN)
	begin
		if (!syncRstN)
		begin
			wPtr <= '0;
			rPtr <= '0;
			count <= '0;
			rvd <= 1'b0;
		end
		else
		begin
			if (push)
				wPtr <= wPtr + 1'b1;
			if (pop)
				rPtr <= rPtr + 1'b1;
			// simultaneous push and pop keeps the count
			if (push & ~pop)
				count <= count + 1'b1;
			else if (pop & ~push)
				count <= count - 1'b1;
			rvd <= pop;
		end
	end

	// storage and registered read port
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wPtr] <= wd;
		if (pop)
			rd <= mem[rPtr];
	end

	// no push while full
	assert property (@(posedge clk) disable iff (!syncRstN) we |-> !full)
		else $error("fifoController: push while full");

endmodule

/* rtl/RAMDualClkFifo.sv */
module RAMDualClkFifo (
	// system request side
	input  logic                                    sysClk,
	input  logic                                    rstN,
	input  logic [ramBridgePkg::lpRamDqWidth-1:0]   wd,
	input  logic [ramBridgePkg::lpRamAdrsWidth-1:0] adrs,
	input  logic                                    cmd,
	input  logic                                    wEd,
	input  logic [ramBridgePkg::lpUfiIdNumber-1:0]  ufiId,
	output logic                                    full,
	// memory request side
	input  logic                                    memClk,
	input  logic                                    rEd,
	output logic [ramBridgePkg::lpRamDqWidth-1:0]   memWd,
	output logic [ramBridgePkg::lpRamAdrsWidth-1:0] memAdrs,
	output logic                                    memCmd,
	output logic                                    emp,
	output logic                                    rVd,
	// return side
	input  logic [ramBridgePkg::lpRamDqWidth-1:0]   retWd,
	input  logic                                    retWEd,
	output logic                                    retFull,
	input  logic                                    memRe,
	output logic [ramBridgePkg::lpRamDqWidth-1:0]   memRd,
	output logic                                    memRvd,
	output logic [ramBridgePkg::lpUfiIdNumber-1:0]  ufiIdOut
);

	import ramBridgePkg::*;

	logic retEmp;
	logic retPop;
	logic idWe;
	logic idEmp;

	// --------------------------------------------------
	// request lanes, sysClk to memClk
	// --------------------------------------------------

	// three lanes move in lockstep, data lane flags stand for all
	fifoDualControllerGray #(
		.pDepth (lpDualClkFifoDepth),
		.pWidth (lpRamDqWidth)
	) u_fifoWd (
		.srcClk (sysClk),
		.dstClk (memClk),
		.rstN   (rstN),
		.wd     (wd),
		.we     (wEd),
		.re     (rEd),
		.full   (full),
		.rd     (memWd),
		.rvd    (rVd),
		.emp    (emp)
	);

	fifoDualControllerGray #(
		.pDepth (lpDualClkFifoDepth),
		.pWidth (lpRamAdrsWidth)
	) u_fifoAdrs (
		.srcClk (sysClk),
		.dstClk (memClk),
		.rstN   (rstN),
		.wd     (adrs),
		.we     (wEd),
		.re     (rEd),
		.full   (),
		.rd     (memAdrs),
		.rvd    (),
		.emp    ()
	);

	fifoDualControllerGray #(
		.pDepth (lpDualClkFifoDepth),
		.pWidth (1)
	) u_fifoCmd (
		.srcClk (sysClk),
		.dstClk (memClk),
		.rstN   (rstN),
		.wd     (cmd),
		.we     (wEd),
		.re     (rEd),
		.full   (),
		.rd     (memCmd),
		.rvd    (),
		.emp    ()
	);

	// --------------------------------------------------
	// return lane, memClk to sysClk
	// --------------------------------------------------

	// client level memRe pops whenever a word is waiting
	assign retPop = memRe & ~retEmp;

	fifoDualControllerGray #(
		.pDepth (lpDualClkFifoDepth),
		.pWidth (lpRamDqWidth)
	) u_fifoRet (
		.srcClk (memClk),
		.dstClk (sysClk),
		.rstN   (rstN),
		.wd     (retWd),
		.we     (retWEd),
		.re     (retPop),
		.full   (retFull),
		.rd     (memRd),
		.rvd    (memRvd),
		.emp    (retEmp)
	);

	// --------------------------------------------------
	// id pairing, sysClk only
	// --------------------------------------------------

	// only reads come back, so only read ids are kept
	assign idWe = wEd & ~full & (cmd == lpCmdRead);

	// popped with the return word, id lands with memRvd
	fifoController #(
		.pDepth (lpIdFifoDepth),
		.pWidth (lpUfiIdNumber)
	) u_fifoId (
		.clk    (sysClk),
		.rstN   (rstN),
		.wd     (ufiId),
		.we     (idWe),
		.re     (retPop),
		.full   (),
		.rd     (ufiIdOut),
		.rvd    (),
		.emp    (idEmp)
	);

	// every returned word must have an id issued before it
	assert property (@(posedge sysClk) disable iff (!rstN) retPop |-> !idEmp)
		else $error("RAMDualClkFifo: return word without a pending id");

endmodule

/* rtl/ramCmdExecutor.sv */
module ramCmdExecutor (
	input  logic                                    memClk,
	input  logic                                    rstN,
	input  logic                                    emp,
	input  logic                                    rVd,
	input  logic [ramBridgePkg::lpRamDqWidth-1:0]   memWd,
	input  logic [ramBridgePkg::lpRamAdrsWidth-1:0] memAdrs,
	input  logic                                    memCmd,
	input  logic                                    retFull,
	output logic                                    rEd,
	output logic [ramBridgePkg::lpRamDqWidth-1:0]   retWd,
	output logic                                    retWEd
);

	import ramBridgePkg::*;

	// on-chip array standing in for the external sram
	logic [lpRamDqWidth-1:0] ramArray [1 << lpRamAdrsWidth];
	logic                    waitVd;
	logic                    isRead;
	logic                    isWrite;

	assign isRead = (memCmd == lpCmdRead);
	assign isWrite = (memCmd == lpCmdWrite);

	// --------------------------------------------------
	// sequencer, idle or waiting for rVd
	// --------------------------------------------------

	// one request in flight
	// a pending return push blocks the next pop, retFull would lag it
	assign rEd = ~waitVd & ~emp & ~retFull & ~retWEd;

	always_ff @(posedge memClk or negedge rstN)
	begin
		if (!rstN)
		begin
			waitVd <= 1'b0;
			retWEd <= 1'b0;
		end
		else
		begin
			if (rEd)
				waitVd <= 1'b1;
			else if (rVd)
				waitVd <= 1'b0;
			// read result goes out the cycle after rVd
			retWEd <= rVd & isRead;
		end
	end

	// --------------------------------------------------
	// array access
	// --------------------------------------------------

	// write data lands when its request arrives
	always_ff @(posedge memClk)
	begin
		if (rVd & isWrite)
			ramArray[memAdrs] <= memWd;
	end

	// synchronous read, data held until the next read
	always_ff @(posedge memClk)
	begin
		if (rVd & isRead)
			retWd <= ramArray[memAdrs];
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// issue gate keeps room for every read result
	assert property (@(posedge memClk) disable iff (!rstN) retWEd |-> !retFull)
		else $error("ramCmdExecutor: return push while full");

endmodule

/* rtl/ramBridgeTop.sv */
module ramBridgeTop (
	// clocks and reset
	input  logic                                    sysClk,
	input  logic                                    memClk,
	input  logic                                    rstN,
	// system requests
	input  logic [ramBridgePkg::lpRamDqWidth-1:0]   wd,
	input  logic [ramBridgePkg::lpRamAdrsWidth-1:0] adrs,
	input  logic                                    cmd,
	input  logic                                    wEd,
	input  logic [ramBridgePkg::lpUfiIdNumber-1:0]  ufiId,
	output logic                                    full,
	// system returns
	input  logic                                    memRe,
	output logic [ramBridgePkg::lpRamDqWidth-1:0]   memRd,
	output logic                                    memRvd,
	output logic [ramBridgePkg::lpUfiIdNumber-1:0]  ufiIdOut
);

	import ramBridgePkg::*;

	// --------------------------------------------------
	// memClk side wiring
	// --------------------------------------------------
	logic                      rEd;
	logic                      emp;
	logic                      rVd;
	logic [lpRamDqWidth-1:0]   memWd;
	logic [lpRamAdrsWidth-1:0] memAdrs;
	logic                      memCmd;
	logic [lpRamDqWidth-1:0]   retWd;
	logic                      retWEd;
	logic                      retFull;

	// clock crossing, request and return lanes
	RAMDualClkFifo u_bridge (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.wd       (wd),
		.adrs     (adrs),
		.cmd      (cmd),
		.wEd      (wEd),
		.ufiId    (ufiId),
		.full     (full),
		.memClk   (memClk),
		.rEd      (rEd),
		.memWd    (memWd),
		.memAdrs  (memAdrs),
		.memCmd   (memCmd),
		.emp      (emp),
		.rVd      (rVd),
		.retWd    (retWd),
		.retWEd   (retWEd),
		.retFull  (retFull),
		.memRe    (memRe),
		.memRd    (memRd),
		.memRvd   (memRvd),
		.ufiIdOut (ufiIdOut)
	);

	// request execution against the array
	ramCmdExecutor u_executor (
		.memClk  (memClk),
		.rstN    (rstN),
		.emp     (emp),
		.rVd     (rVd),
		.memWd   (memWd),
		.memAdrs (memAdrs),
		.memCmd  (memCmd),
		.retFull (retFull),
		.rEd     (rEd),
		.retWd   (retWd),
		.retWEd  (retWEd)
	);

endmodule

/* testbench/tbRamBridge.sv */
module tbRamBridge;

	import ramBridgePkg::*;

	// cycles any single wait may spin before the run is stopped
	localparam int lpWaitLimit = 2000;
	localparam int lpRandomOps = 400;

	logic                      sysClk;
	logic                      memClk;
	logic                      rstN;
	logic [lpRamDqWidth-1:0]   wd;
	logic [lpRamAdrsWidth-1:0] adrs;
	logic                      cmd;
	logic                      wEd;
	logic [lpUfiIdNumber-1:0]  ufiId;
	logic                      full;
	logic                      memRe;
	logic [lpRamDqWidth-1:0]   memRd;
	logic                      memRvd;
	logic [lpUfiIdNumber-1:0]  ufiIdOut;

	// random memRe while set
	logic                      toggleRe;

	// shadow of the array as seen by the request stream
	logic [lpRamDqWidth-1:0]   shadow [1 << lpRamAdrsWidth];
	logic [lpRamDqWidth-1:0]   expData [$];
	logic [lpUfiIdNumber-1:0]  expId [$];
	logic [lpRamAdrsWidth-1:0] writtenAdrs [$];
	logic [lpRamDqWidth-1:0]   headData;
	logic [lpUfiIdNumber-1:0]  headId;
	int unsigned               seedInit;
	int                        issued;

	ramBridgeTop u_ramBridgeTop (
		.sysClk   (sysClk),
		.memClk   (memClk),
		.rstN     (rstN),
		.wd       (wd),
		.adrs     (adrs),
		.cmd      (cmd),
		.wEd      (wEd),
		.ufiId    (ufiId),
		.full     (full),
		.memRe    (memRe),
		.memRd    (memRd),
		.memRvd   (memRvd),
		.ufiIdOut (ufiIdOut)
	);

	// --------------------------------------------------
	// clocks, unrelated periods
	// --------------------------------------------------
	always #20 sysClk = ~sysClk;
	always #14 memClk = ~memClk;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic abortRun();
		$display("Result: FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abortRun();
		end
	endtask

	// in-order execution, a read sees every write issued before it
	function automatic logic [lpRamDqWidth-1:0] expectRd(input logic [lpRamAdrsWidth-1:0] a);
		return shadow[a];
	endfunction

	// one strobe, only in a cycle where full is low
	task automatic issueReq(input logic c, input logic [lpRamAdrsWidth-1:0] a,
		input logic [lpRamDqWidth-1:0] d, input logic [lpUfiIdNumber-1:0] id);
		int waited;
		waited = 0;
		while (full)
		begin
			if (waited >= lpWaitLimit)
			begin
				$display("timeout: full stayed high, request could not be issued");
				abortRun();
			end
			@(posedge sysClk);
			#2;
			waited++;
		end
		cmd = c;
		adrs = a;
		wd = d;
		ufiId = id;
		wEd = 1'b1;
		@(posedge sysClk);
		#2;
		wEd = 1'b0;
	endtask

	task automatic writeWord(input logic [lpRamAdrsWidth-1:0] a,
		input logic [lpRamDqWidth-1:0] d);
		shadow[a] = d;
		writtenAdrs.push_back(a);
		issueReq(lpCmdWrite, a, d, '0);
	endtask

	task automatic readWord(input logic [lpRamAdrsWidth-1:0] a,
		input logic [lpUfiIdNumber-1:0] id);
		// expected value fixed at issue time
		expData.push_back(expectRd(a));
		expId.push_back(id);
		issueReq(lpCmdRead, a, '0, id);
	endtask

	// until every expected word is back, then a short settle for strays
	task automatic waitDrained();
		int waited;
		waited = 0;
		while (expData.size() != 0)
		begin
			if (waited >= lpWaitLimit)
			begin
				$display("timeout: %0d read words never returned", expData.size());
				abortRun();
			end
			@(posedge sysClk);
			#2;
			waited++;
		end
		repeat (20) @(posedge sysClk);
		#2;
	endtask

	// --------------------------------------------------
	// return checker, sampled mid-cycle
	// --------------------------------------------------
	always @(negedge sysClk)
	begin
		if (rstN === 1'b1 && memRvd === 1'b1)
		begin
			if (expData.size() == 0)
			begin
				$display("error: read word returned with no read outstanding");
				abortRun();
			end
			headData = expData.pop_front();
			headId = expId.pop_front();
			checkValue("memRd", memRd, headData);
			checkValue("ufiIdOut", ufiIdOut, headId);
		end
	end

	// random memRe level, same offset as other stimulus
	always @(posedge sysClk)
	begin
		#2;
		if (toggleRe)
			memRe = ($urandom % 3) != 0;
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial
	begin
		seedInit = $urandom(32'h2e4b);
		sysClk = 1'b0;
		memClk = 1'b0;
		rstN = 1'b0;
		wd = '0;
		adrs = '0;
		cmd = lpCmdWrite;
		wEd = 1'b0;
		ufiId = '0;
		memRe = 1'b0;
		toggleRe = 1'b0;
		issued = 0;

		repeat (16) @(posedge sysClk);
		#2;
		rstN = 1'b1;
		// let the per-domain reset syncs release
		repeat (6) @(posedge sysClk);
		#2;

		// reset state
		checkValue("full", full, 1'b0);
		checkValue("memRvd", memRvd, 1'b0);

		// read after write
		memRe = 1'b1;
		writeWord(10'h155, 8'ha7);
		readWord(10'h155, 3'd5);
		waitDrained();

		// ordering, eight reads held outstanding then released
		for (int i = 0; i < 8; i++)
			writeWord(10'(i * 37 + 3), 8'(8'h30 + i * 11));
		memRe = 1'b0;
		for (int i = 0; i < 8; i++)
			readWord(10'(i * 37 + 3), 3'(7 - i));
		checkValue("outstanding", expData.size(), 8);
		memRe = 1'b1;
		waitDrained();

		// back-pressure, return lane blocked until full rises
		memRe = 1'b0;
		while (!full && issued < 48)
		begin
			readWord(10'((issued % 8) * 37 + 3), 3'(issued));
			issued++;
		end
		checkValue("full", full, 1'b1);
		repeat (10) @(posedge sysClk);
		#2;
		memRe = 1'b1;
		waitDrained();

		// random mix, reads only to written addresses
		toggleRe = 1'b1;
		for (int i = 0; i < lpRandomOps; i++)
		begin
			if (writtenAdrs.size() == 0 || ($urandom % 2) == 0)
				writeWord(10'($urandom), 8'($urandom));
			else
				readWord(writtenAdrs[$urandom % writtenAdrs.size()], 3'($urandom));
			// occasional idle cycle
			if (($urandom % 4) == 0)
			begin
				@(posedge sysClk);
				#2;
			end
		end
		toggleRe = 1'b0;
		memRe = 1'b1;
		waitDrained();

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* compile.f */
rtl/ramBridgePkg.sv
rtl/fifoDualControllerGray.sv
rtl/fifoController.sv
rtl/RAMDualClkFifo.sv
rtl/ramCmdExecutor.sv
rtl/ramBridgeTop.sv
testbench/tbRamBridge.sv
